// File: run_sim.sh
#!/usr/bin/env bash
# Build the trap subsystem testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f trap_top.f --top-module trap_top_tb \
  -o trap_sim > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/trap_sim > sim.log 2>&1

grep -qx "test passed" sim.log \
  && echo "simulation PASS" \
  || { echo "simulation FAIL, see sim.log"; exit 1; }

// File: tb_clkgen.sv
// Testbench clock and reset source: 4 ns clock, reset held low for the first four cycles
`timescale 1ns/100ps

module tb_clkgen #(
  parameter real         half_period = 2.0,
  parameter int unsigned rst_cycles  = 4
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(half_period) clk_o = ~clk_o;
  end

  // Release just after an edge so the first captured cycle is a clean one
  initial begin
    rst_no = 1'b0;
    repeat (rst_cycles) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

// File: trap_csr.sv
// Trap CSR file: holds mepc, mcause, mstatus and mie and registers the trap strobe
`timescale 1ns/100ps
`include "trap_params.svh"

module trap_csr import trap_pkg::*; (
  input  logic     clk,
  input  logic     rst_ni,
  input  logic     take_i,
  input  trap_t    trap_i,
  input  logic     mret_i,
  input  logic     csr_we_i,
  input  csr_wr_t  csr_wr_i,
  output logic     trap_valid_o,
  output trap_t    trap_o,
  output word_t    mepc_o,
  output word_t    mcause_o,
  output logic     mstatus_mie_o,
  output logic     mstatus_mpie_o,
  output irq_vec_t mie_o
);

  logic wr_mstatus;
  logic wr_mie;

  // Decoded write targets of the captured CSR write
  assign wr_mstatus = csr_we_i && (csr_wr_i.addr == CSR_MSTATUS);
  assign wr_mie     = csr_we_i && (csr_wr_i.addr == CSR_MIE);

  ////////////////////////////////////////////////////////////////////////////
  // Trap strobe and saved cause
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      trap_valid_o <= 1'b0;
      mepc_o       <= '0;
      mcause_o     <= '0;
    end else begin
      trap_valid_o <= take_i;
      if (take_i) begin
        mepc_o   <= trap_i.pc;
        // Interrupt flag in bit 31, code in the low five bits
        mcause_o <= {trap_i.irq, {26{1'b0}}, trap_i.code};
      end
    end
  end

  // The decision itself travels with the strobe
  always_ff @(posedge clk) begin
    if (take_i) begin
      trap_o <= trap_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // mstatus and mie
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mstatus_mie_o  <= `TRAP_MSTATUS_RST;
      mstatus_mpie_o <= 1'b0;
      mie_o          <= `TRAP_MIE_RST;
    end else begin
      // Trap entry beats MRET and software writes to mstatus in the same slot
      if (take_i) begin
        mstatus_mpie_o <= mstatus_mie_o;
        mstatus_mie_o  <= 1'b0;
      end else if (mret_i) begin
        mstatus_mie_o  <= mstatus_mpie_o;
        mstatus_mpie_o <= 1'b1;
      end else if (wr_mstatus) begin
        mstatus_mie_o  <= csr_wr_i.wdata[3];
        mstatus_mpie_o <= csr_wr_i.wdata[7];
      end
      // mie is not touched by trap entry, so its write always lands
      if (wr_mie) begin
        mie_o <= csr_wr_i.wdata[`TRAP_IRQ_NUM-1:0];
      end
    end
  end

  // While the trap strobe is out, interrupts are masked and the previous
  // enable sits in mpie
  a_trap_masks_irq : assert property (
    @(posedge clk) disable iff (!rst_ni)
    trap_valid_o |-> !mstatus_mie_o && (mstatus_mpie_o == $past(mstatus_mie_o))
  );

endmodule

// File: trap_params.svh
// Trap subsystem build parameters: interrupt count, trap vector base and CSR reset values
`ifndef TRAP_PARAMS_SVH
`define TRAP_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Interrupts and trap vector
////////////////////////////////////////////////////////////////////////////

// Number of interrupt request lines, one per mie bit
`define TRAP_IRQ_NUM 16

// Trap vector base, exceptions land here and interrupts at base plus 4 * cause
`define TRAP_MTVEC 32'h0000_1000

////////////////////////////////////////////////////////////////////////////
// Reset values
////////////////////////////////////////////////////////////////////////////

// Global interrupt enable comes up off
`define TRAP_MSTATUS_RST 1'b0
// All individual interrupt enables come up off
`define TRAP_MIE_RST {`TRAP_IRQ_NUM{1'b0}}

`endif

// File: trap_pkg.sv
// Shared types of the trap subsystem: words, cause codes, CSR addresses and pipeline records
`include "trap_params.svh"

package trap_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Plain vector types
  ////////////////////////////////////////////////////////////////////////////

  // Machine word, used for PCs and CSR contents
  typedef logic [31:0] word_t;

  // One bit per interrupt line, same layout as mie and irq_i
  typedef logic [`TRAP_IRQ_NUM-1:0] irq_vec_t;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // Synchronous exception causes written to mcause[4:0] with bit 31 clear
  typedef enum logic [4:0] {
    INSTR_FAULT     = 5'd1,
    ILLEGAL_INSN    = 5'd2,
    BREAKPOINT      = 5'd3,
    ECALL_MMODE     = 5'd11,
    INSTR_BUS_FAULT = 5'd24
  } exc_code_e;

  // Writable CSRs, everything else is not modelled
  typedef enum logic [11:0] {
    CSR_MSTATUS = 12'h300,
    CSR_MIE     = 12'h304
  } csr_addr_e;

  ////////////////////////////////////////////////////////////////////////////
  // Records
  ////////////////////////////////////////////////////////////////////////////

  // One retiring instruction with its exception flags
  typedef struct packed {
    word_t pc;
    logic  mpu_err;
    logic  bus_err;
    logic  illegal;
    logic  ecall;
    logic  ebrk;
  } ex_wb_t;

  // A software CSR write
  typedef struct packed {
    csr_addr_e addr;
    word_t     wdata;
  } csr_wr_t;

  // A trap decision, pc is the value saved to mepc
  typedef struct packed {
    logic       irq;
    logic [4:0] code;
    word_t      pc;
    word_t      target;
  } trap_t;

endpackage

// File: trap_prioritizer.sv
// Trap decision logic: picks an enabled interrupt or the highest priority exception of a slot
`timescale 1ns/100ps
`include "trap_params.svh"

module trap_prioritizer import trap_pkg::*; (
  input  logic     slot_valid_i,
  input  ex_wb_t   slot_i,
  input  irq_vec_t irq_i,
  input  irq_vec_t mie_i,
  input  logic     mstatus_mie_i,
  output logic     take_o,
  output trap_t    trap_o
);

  localparam int unsigned IdxW = $clog2(`TRAP_IRQ_NUM);

  irq_vec_t          irq_pend;
  logic              irq_take;
  logic [IdxW-1:0]   irq_idx;
  logic              exc_any;
  exc_code_e         exc_code;

  ////////////////////////////////////////////////////////////////////////////
  // Interrupts
  ////////////////////////////////////////////////////////////////////////////

  // Only lines that are both pending and individually enabled count
  assign irq_pend = irq_i & mie_i;
  assign irq_take = slot_valid_i && mstatus_mie_i && (|irq_pend);

  // Lowest set index wins, scan from the top so the last hit is the lowest
  always_comb begin
    irq_idx = '0;
    for (int i = `TRAP_IRQ_NUM - 1; i >= 0; i--) begin
      if (irq_pend[i]) begin
        irq_idx = i[IdxW-1:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Exceptions
  ////////////////////////////////////////////////////////////////////////////

  assign exc_any = slot_i.mpu_err | slot_i.bus_err | slot_i.illegal |
                   slot_i.ecall | slot_i.ebrk;

  // Fixed priority, fetch side faults first, then decode, then environment calls
  always_comb begin
    if (slot_i.mpu_err) begin
      exc_code = INSTR_FAULT;
    end else if (slot_i.bus_err) begin
      exc_code = INSTR_BUS_FAULT;
    end else if (slot_i.illegal) begin
      exc_code = ILLEGAL_INSN;
    end else if (slot_i.ecall) begin
      exc_code = ECALL_MMODE;
    end else begin
      // Also the idle value, take_o stays low when no flag is set
      exc_code = BREAKPOINT;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Decision
  ////////////////////////////////////////////////////////////////////////////

  // An interrupt overrides any exception in the same slot
  assign take_o = irq_take || (slot_valid_i && exc_any);

  always_comb begin
    trap_o.irq  = irq_take;
    trap_o.code = irq_take ? 5'(irq_idx) : exc_code;
    trap_o.pc   = slot_i.pc;
    // Interrupts are vectored, exceptions all enter at the base
    trap_o.target = irq_take ? (`TRAP_MTVEC + (word_t'(irq_idx) << 2)) : `TRAP_MTVEC;
  end

  // A taken interrupt names a pending enabled line with none pending below it
  always_comb begin
    a_irq_lowest : assert (!irq_take || (irq_pend[irq_idx] &&
      ((irq_pend & ((irq_vec_t'(1) << irq_idx) - irq_vec_t'(1))) == '0)));
  end

endmodule

// File: trap_sva.sv
// Trap checker: matches the first exception of each kind to its saved mepc and checks interrupt enables
`timescale 1ns/100ps
`include "trap_params.svh"

module trap_sva import trap_pkg::*; (
  input logic     clk,
  input logic     rst_ni,
  input logic     slot_valid_i,
  input ex_wb_t   slot_i,
  input logic     take_i,
  input trap_t    trap_i,
  input irq_vec_t mie_i,
  input logic     mstatus_mie_i,
  input word_t    mepc_i,
  input word_t    mcause_i
);

  localparam int unsigned KindNum = 5;
  localparam int unsigned IdxW    = $clog2(`TRAP_IRQ_NUM);

  logic [KindNum-1:0] slot_kind;
  logic [KindNum-1:0] exp_hit;
  logic [KindNum-1:0] act_hit;
  logic [KindNum-1:0] exp_found;
  logic [KindNum-1:0] act_found;
  logic               exc_saved;
  word_t              exp_pc [KindNum];
  word_t              act_pc [KindNum];

  // Kind index in priority order, 0 is MPU fault and 4 is EBREAK
  function automatic exc_code_e kind_code(int unsigned k);
    case (k)
      0:       return INSTR_FAULT;
      1:       return INSTR_BUS_FAULT;
      2:       return ILLEGAL_INSN;
      3:       return ECALL_MMODE;
      default: return BREAKPOINT;
    endcase
  endfunction

  // Highest priority flag of the slot, ignored when an interrupt took the slot
  always_comb begin
    slot_kind = '0;
    if (slot_valid_i && !(take_i && trap_i.irq)) begin
      if (slot_i.mpu_err)      slot_kind[0] = 1'b1;
      else if (slot_i.bus_err) slot_kind[1] = 1'b1;
      else if (slot_i.illegal) slot_kind[2] = 1'b1;
      else if (slot_i.ecall)   slot_kind[3] = 1'b1;
      else if (slot_i.ebrk)    slot_kind[4] = 1'b1;
    end
  end

  // mepc and mcause show an exception entry one cycle after the decision
  always_comb begin
    for (int k = 0; k < KindNum; k++) begin
      exp_hit[k] = !exp_found[k] && slot_kind[k];
      act_hit[k] = !act_found[k] && exc_saved &&
                   (mcause_i == {1'b0, {26{1'b0}}, kind_code(k)});
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      exp_found <= '0;
      act_found <= '0;
      exc_saved <= 1'b0;
    end else begin
      exp_found <= exp_found | exp_hit;
      act_found <= act_found | act_hit;
      exc_saved <= take_i && !trap_i.irq;
    end
  end

  // First PC seen and first mepc saved, per kind
  always_ff @(posedge clk) begin
    for (int k = 0; k < KindNum; k++) begin
      if (exp_hit[k]) exp_pc[k] <= slot_i.pc;
      if (act_hit[k]) act_pc[k] <= mepc_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < KindNum; k++) begin : g_mepc
    a_first_mepc : assert property (
      @(posedge clk) disable iff (!rst_ni)
      (exp_found[k] && act_found[k]) |-> (exp_pc[k] == act_pc[k])
    );
  end

  // A taken interrupt was enabled both per line and globally
  a_irq_enabled : assert property (
    @(posedge clk) disable iff (!rst_ni)
    (take_i && trap_i.irq) |-> (mie_i[trap_i.code[IdxW-1:0]] && mstatus_mie_i)
  );

  // After an interrupt mcause names it and further interrupts are masked
  a_irq_cause : assert property (
    @(posedge clk) disable iff (!rst_ni)
    (take_i && trap_i.irq) |=>
      (mcause_i == {1'b1, {26{1'b0}}, $past(trap_i.code)}) && !mstatus_mie_i
  );

endmodule

// File: trap_top.f
+incdir+.
trap_pkg.sv
wb_capture.sv
trap_prioritizer.sv
trap_csr.sv
trap_sva.sv
trap_top.sv
tb_clkgen.sv
trap_top_tb.sv

// File: trap_top.sv
// Trap subsystem top: capture stage, prioritizer, CSR file and checker
`timescale 1ns/100ps

module trap_top import trap_pkg::*; (
  input  logic     clk,
  input  logic     rst_ni,
  input  logic     retire_i,
  input  ex_wb_t   instr_i,
  input  irq_vec_t irq_i,
  input  logic     mret_i,
  input  logic     csr_we_i,
  input  csr_wr_t  csr_wr_i,
  output logic     trap_valid_o,
  output trap_t    trap_o,
  output word_t    mepc_o,
  output word_t    mcause_o,
  output logic     mstatus_mie_o,
  output logic     mstatus_mpie_o,
  output irq_vec_t mie_o
);

  // Captured slot
  logic     slot_valid;
  ex_wb_t   slot;
  irq_vec_t slot_irq;
  logic     slot_mret;
  logic     slot_csr_we;
  csr_wr_t  slot_csr_wr;

  // Decision
  logic     take;
  trap_t    trap;

  wb_capture u_capture (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .retire_i     (retire_i),
    .instr_i      (instr_i),
    .irq_i        (irq_i),
    .mret_i       (mret_i),
    .csr_we_i     (csr_we_i),
    .csr_wr_i     (csr_wr_i),
    .slot_valid_o (slot_valid),
    .slot_o       (slot),
    .irq_o        (slot_irq),
    .mret_o       (slot_mret),
    .csr_we_o     (slot_csr_we),
    .csr_wr_o     (slot_csr_wr)
  );

  trap_prioritizer u_prio (
    .slot_valid_i  (slot_valid),
    .slot_i        (slot),
    .irq_i         (slot_irq),
    .mie_i         (mie_o),
    .mstatus_mie_i (mstatus_mie_o),
    .take_o        (take),
    .trap_o        (trap)
  );

  trap_csr u_csr (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .take_i         (take),
    .trap_i         (trap),
    .mret_i         (slot_mret),
    .csr_we_i       (slot_csr_we),
    .csr_wr_i       (slot_csr_wr),
    .trap_valid_o   (trap_valid_o),
    .trap_o         (trap_o),
    .mepc_o         (mepc_o),
    .mcause_o       (mcause_o),
    .mstatus_mie_o  (mstatus_mie_o),
    .mstatus_mpie_o (mstatus_mpie_o),
    .mie_o          (mie_o)
  );

  trap_sva u_sva (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .slot_valid_i  (slot_valid),
    .slot_i        (slot),
    .take_i        (take),
    .trap_i        (trap),
    .mie_i         (mie_o),
    .mstatus_mie_i (mstatus_mie_o),
    .mepc_i        (mepc_o),
    .mcause_i      (mcause_o)
  );

endmodule

// File: trap_top_tb.sv
// Trap subsystem testbench: random and directed retires checked against a reference model
`timescale 1ns/100ps
`include "trap_params.svh"

module trap_top_tb import trap_pkg::*; ();

  // One cycle of DUT inputs
  typedef struct packed {
    logic     retire;
    ex_wb_t   instr;
    irq_vec_t irq;
    logic     mret;
    logic     csr_we;
    csr_wr_t  csr_wr;
  } stim_t;

  // CSR state as the model sees it, same meaning as the DUT outputs
  typedef struct packed {
    logic     st_mie;
    logic     st_mpie;
    irq_vec_t mie;
    word_t    mepc;
    word_t    mcause;
  } csr_state_t;

  // Expected outputs two cycles after a stimulus cycle
  typedef struct packed {
    logic       valid;
    trap_t      trap;
    csr_state_t st;
  } expect_t;

  typedef struct packed {
    logic [31:0] due;
    expect_t     exp;
  } pending_t;

  logic        clk;
  logic        rst_ni;
  logic        retire;
  ex_wb_t      instr;
  irq_vec_t    irq;
  logic        mret;
  logic        csr_we;
  csr_wr_t     csr_wr;
  logic        trap_valid;
  trap_t       trap_out;
  word_t       mepc;
  word_t       mcause;
  logic        st_mie;
  logic        st_mpie;
  irq_vec_t    mie;
  logic [31:0] lfsr;
  logic [31:0] cyc;
  csr_state_t  model;
  pending_t    pend_q[$];
  int          checks;
  int          errors;
  logic        timed_out;

  tb_clkgen u_clkgen (
    .clk_o  (clk),
    .rst_no (rst_ni)
  );

  trap_top dut_i (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .retire_i       (retire),
    .instr_i        (instr),
    .irq_i          (irq),
    .mret_i         (mret),
    .csr_we_i       (csr_we),
    .csr_wr_i       (csr_wr),
    .trap_valid_o   (trap_valid),
    .trap_o         (trap_out),
    .mepc_o         (mepc),
    .mcause_o       (mcause),
    .mstatus_mie_o  (st_mie),
    .mstatus_mpie_o (st_mpie),
    .mie_o          (mie)
  );

  // Edge counter, a prediction made after edge c is due after edge c + 2
  always @(posedge clk) begin
    cyc <= cyc + 32'd1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random numbers and stimulus records
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic stim_t retire_stim(word_t pc, logic [4:0] flags, irq_vec_t lines);
    stim_t s;
    s = '0;
    s.retire = 1'b1;
    s.instr.pc = pc;
    // Flag order is MPU fault, bus error, illegal, ECALL, EBREAK
    {s.instr.mpu_err, s.instr.bus_err, s.instr.illegal, s.instr.ecall, s.instr.ebrk} = flags;
    s.irq = lines;
    return s;
  endfunction

  function automatic stim_t csr_stim(csr_addr_e addr, word_t wdata);
    stim_t s;
    s = '0;
    s.csr_we = 1'b1;
    s.csr_wr.addr = addr;
    s.csr_wr.wdata = wdata;
    return s;
  endfunction

  function automatic stim_t random_stim(logic irq_on, logic csr_on);
    stim_t       s;
    logic [31:0] w;
    logic [31:0] v;
    s = '0;
    w = take_bits(2);
    s.retire = (w[1:0] != 2'b00);
    w = take_bits(30);
    s.instr.pc = {w[29:0], 2'b00};
    // Each flag about one in four, and a quarter of the retires carry none
    w = take_bits(12);
    if (w[11:10] != 2'b00) begin
      {s.instr.mpu_err, s.instr.bus_err, s.instr.illegal, s.instr.ecall, s.instr.ebrk} =
        w[4:0] & w[9:5];
    end
    // A fetch reports an MPU fault or a bus error, never both
    if (s.instr.mpu_err) s.instr.bus_err = 1'b0;
    if (irq_on) begin
      w = take_bits(`TRAP_IRQ_NUM);
      v = take_bits(`TRAP_IRQ_NUM);
      w = w & v;
      s.irq = w[`TRAP_IRQ_NUM-1:0];
    end
    if (csr_on) begin
      w = take_bits(4);
      s.mret = (w[1:0] == 2'b00);
      s.csr_we = (w[3:2] == 2'b00);
      w = take_bits(17);
      s.csr_wr.addr = w[16] ? CSR_MIE : CSR_MSTATUS;
      s.csr_wr.wdata = {16'h0000, w[15:0]};
    end
    return s;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic expect_t predict(stim_t s, csr_state_t cur);
    expect_t  e;
    irq_vec_t pend;
    logic     found;
    e = '0;
    e.st = cur;
    pend = s.irq & cur.mie;
    found = 1'b0;
    // An interrupt needs a retire slot, the global enable and a pending enabled line
    if (s.retire && cur.st_mie) begin
      for (int i = 0; i < `TRAP_IRQ_NUM; i++) begin
        if (pend[i] && !found) begin
          found = 1'b1;
          e.trap.code = 5'(i);
        end
      end
    end
    if (found) begin
      e.valid = 1'b1;
      e.trap.irq = 1'b1;
      e.trap.target = `TRAP_MTVEC + {25'b0, e.trap.code, 2'b00};
    end else if (s.retire) begin
      e.valid = 1'b1;
      e.trap.target = `TRAP_MTVEC;
      if (s.instr.mpu_err) e.trap.code = INSTR_FAULT;
      else if (s.instr.bus_err) e.trap.code = INSTR_BUS_FAULT;
      else if (s.instr.illegal) e.trap.code = ILLEGAL_INSN;
      else if (s.instr.ecall) e.trap.code = ECALL_MMODE;
      else if (s.instr.ebrk) e.trap.code = BREAKPOINT;
      else e.valid = 1'b0;
    end
    // Trap entry first, then MRET, then a software write to mstatus
    if (e.valid) begin
      e.trap.pc = s.instr.pc;
      e.st.mepc = s.instr.pc;
      e.st.mcause = {e.trap.irq, 26'b0, e.trap.code};
      e.st.st_mpie = cur.st_mie;
      e.st.st_mie = 1'b0;
    end else if (s.mret) begin
      e.st.st_mie = cur.st_mpie;
      e.st.st_mpie = 1'b1;
    end else if (s.csr_we && s.csr_wr.addr == CSR_MSTATUS) begin
      e.st.st_mie = s.csr_wr.wdata[3];
      e.st.st_mpie = s.csr_wr.wdata[7];
    end
    if (s.csr_we && s.csr_wr.addr == CSR_MIE) e.st.mie = s.csr_wr.wdata[`TRAP_IRQ_NUM-1:0];
    return e;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_val(string name, logic [31:0] act, logic [31:0] exp);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED at %0.1f ns: %s is %h, expected %h", $realtime, name, act, exp);
    end
  endtask

  task automatic compare_outputs(expect_t e);
    check_val("trap_valid_o", 32'(trap_valid), 32'(e.valid));
    // The strobe payload only means something while the strobe is high
    if (e.valid) begin
      check_val("trap_o.irq", 32'(trap_out.irq), 32'(e.trap.irq));
      check_val("trap_o.code", 32'(trap_out.code), 32'(e.trap.code));
      check_val("trap_o.pc", trap_out.pc, e.trap.pc);
      check_val("trap_o.target", trap_out.target, e.trap.target);
    end
    check_val("mepc_o", mepc, e.st.mepc);
    check_val("mcause_o", mcause, e.st.mcause);
    check_val("mstatus_mie_o", 32'(st_mie), 32'(e.st.st_mie));
    check_val("mstatus_mpie_o", 32'(st_mpie), 32'(e.st.st_mpie));
    check_val("mie_o", 32'(mie), 32'(e.st.mie));
  endtask

  // Outputs settle after the rising edge, so they are compared on the falling one
  always @(negedge clk) begin : compare
    pending_t p;
    while (pend_q.size() != 0 && pend_q[0].due <= cyc) begin
      p = pend_q.pop_front();
      if (p.due != cyc) begin
        errors++;
        $display("ERROR: prediction due after edge %0d was still queued at edge %0d",
                 p.due, cyc);
      end else begin
        compare_outputs(p.exp);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Driving
  ////////////////////////////////////////////////////////////////////////////

  task automatic apply(stim_t s);
    retire = s.retire;
    instr  = s.instr;
    irq    = s.irq;
    mret   = s.mret;
    csr_we = s.csr_we;
    csr_wr = s.csr_wr;
  endtask

  // One stimulus cycle, driven 1 ns after the edge and predicted at once
  task automatic drive(stim_t s);
    expect_t e;
    @(posedge clk);
    #1;
    apply(s);
    e = predict(s, model);
    model = e.st;
    pend_q.push_back('{due: cyc + 32'd2, exp: e});
  endtask

  task automatic drain(string what);
    int n;
    @(posedge clk);
    #1;
    apply('0);
    n = 0;
    while (pend_q.size() != 0 && n < 16) begin
      @(posedge clk);
      n++;
    end
    if (pend_q.size() != 0) begin
      $display("ERROR: timed out waiting for the %s results to come out", what);
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (!rst_ni && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (!rst_ni) begin
      $display("ERROR: timed out waiting for reset to be released");
      timed_out = 1'b1;
    end
  endtask

  task automatic close_test(string name, int c0, int e0);
    drain(name);
    $display("%s: %0d checks, %0d mismatches", name, checks - c0, errors - e0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  // An idle cycle against the reset state of the model
  task automatic reset_test();
    int c0;
    int e0;
    c0 = checks;
    e0 = errors;
    drive('0);
    close_test("reset state", c0, e0);
  endtask

  // Interrupt lines toggle but mie is still zero from reset
  task automatic exc_priority_test();
    int c0;
    int e0;
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 48; i++) begin
      drive(random_stim(1'b1, 1'b0));
    end
    close_test("exception priority", c0, e0);
  endtask

  task automatic irq_gating_test();
    int          c0;
    int          e0;
    logic [31:0] w;
    c0 = checks;
    e0 = errors;
    w = take_bits(16);
    drive(csr_stim(CSR_MIE, {16'h0000, w[15:0] | 16'h0001}));
    drive(csr_stim(CSR_MSTATUS, 32'h0000_0008));
    // Random writes and MRETs keep turning the global enable back on
    for (int i = 0; i < 96; i++) begin
      drive(random_stim(1'b1, 1'b1));
    end
    close_test("interrupt gating", c0, e0);
  endtask

  task automatic mstatus_test();
    int    c0;
    int    e0;
    stim_t s;
    c0 = checks;
    e0 = errors;
    drive(csr_stim(CSR_MIE, 32'h0000_0001));
    drive(csr_stim(CSR_MSTATUS, 32'h0000_0008));
    drive(retire_stim(32'h0000_4000, 5'b00000, irq_vec_t'(1)));
    // Now masked, so the same pending line is ignored and the clean retire passes
    drive(retire_stim(32'h0000_4004, 5'b00000, irq_vec_t'(1)));
    s = '0;
    s.mret = 1'b1;
    drive(s);
    drive(retire_stim(32'h0000_4008, 5'b00000, irq_vec_t'(1)));
    drive(s);
    // Software tries to set mie in the slot of an illegal instruction
    s = retire_stim(32'h0000_4010, 5'b00100, '0);
    s.csr_we = 1'b1;
    s.csr_wr.addr = CSR_MSTATUS;
    s.csr_wr.wdata = 32'h0000_0008;
    drive(s);
    // MRET in the slot of an EBREAK is dropped
    s = retire_stim(32'h0000_4014, 5'b00001, '0);
    s.mret = 1'b1;
    drive(s);
    s = '0;
    s.mret = 1'b1;
    drive(s);
    close_test("mstatus handling", c0, e0);
  endtask

  task automatic back_to_back_test();
    int          c0;
    int          e0;
    logic [31:0] w;
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 16; i++) begin
      w = take_bits(5);
      if (w[4]) w[3] = 1'b0;
      if (w[4:0] == 5'b00000) w[1] = 1'b1;
      drive(retire_stim(32'h0000_8000 + 32'(4 * i), w[4:0], '0));
    end
    close_test("back-to-back retires", c0, e0);
  endtask

  initial begin
    apply('0);
    lfsr = 32'h5a75;
    cyc = '0;
    model = '0;
    model.st_mie = `TRAP_MSTATUS_RST;
    model.mie = `TRAP_MIE_RST;
    checks = 0;
    errors = 0;
    timed_out = 1'b0;
    wait_reset_release();
    if (!timed_out) reset_test();
    if (!timed_out) exc_priority_test();
    if (!timed_out) irq_gating_test();
    if (!timed_out) mstatus_test();
    if (!timed_out) back_to_back_test();
    $display("total: %0d checks, %0d mismatches, timeout %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: wb_capture.sv
// Writeback capture stage: registers the retiring instruction, interrupt lines, MRET and CSR writes
`timescale 1ns/100ps

module wb_capture import trap_pkg::*; (
  input  logic     clk,
  input  logic     rst_ni,
  input  logic     retire_i,
  input  ex_wb_t   instr_i,
  input  irq_vec_t irq_i,
  input  logic     mret_i,
  input  logic     csr_we_i,
  input  csr_wr_t  csr_wr_i,
  output logic     slot_valid_o,
  output ex_wb_t   slot_o,
  output irq_vec_t irq_o,
  output logic     mret_o,
  output logic     csr_we_o,
  output csr_wr_t  csr_wr_o
);

  // Strobes of the captured slot
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_valid_o <= 1'b0;
      mret_o       <= 1'b0;
      csr_we_o     <= 1'b0;
    end else begin
      slot_valid_o <= retire_i;
      mret_o       <= mret_i;
      csr_we_o     <= csr_we_i;
    end
  end

  // Payload, held between strobes so the slot stays coherent
  always_ff @(posedge clk) begin
    if (retire_i) begin
      slot_o <= instr_i;
    end
    if (csr_we_i) begin
      csr_wr_o <= csr_wr_i;
    end
    // Interrupt lines are levels and are sampled every cycle
    irq_o <= irq_i;
  end

  // The fetch unit reports either an MPU fault or a bus error on one fetch, never both
  a_single_fetch_err : assert property (
    @(posedge clk) disable iff (!rst_ni)
    retire_i |-> !(instr_i.mpu_err && instr_i.bus_err)
  );

endmodule
